// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = procTb
FILELIST  = tb.f
PASSTEXT  = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory and the program copy"
	@echo "  help   show this list"

# the fetch stage loads program.hex from the directory it runs in
program.hex: sim/program.hex
	cp sim/program.hex program.hex

test: program.hex
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASSTEXT)"

clean:
	rm -rf obj_dir program.hex

// File: sim/procTb.sv
// Testbench for the four-stage proc pipeline
// an ISA model runs the same program, the writeback trace is checked in order
module procTb;
   timeunit 1ns;
   timeprecision 1ps;
   import procPkg::*;

   typedef struct packed {
      logic [2:0]           dest;
      logic [dataWidth-1:0] data;
   } wbEntry;

   localparam int stepLimit = 4096;   // bound on model steps

   logic     clk;
   logic     arstN;
   logic     err;
   logic     halted;
   writeBack wbTrace;

   logic [dataWidth-1:0] progMem [imemWords];
   wbEntry               expected [$];
   int                   modelSteps;
   int                   illegalExpected;
   int                   errSeen = 0;

   proc uut (
      .clk     (clk),
      .arstN   (arstN),
      .err     (err),
      .halted  (halted),
      .wbTrace (wbTrace)
   );

   task automatic stopOnFailure();
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped at %0t ns", $time);
   endtask

   task automatic compareValue(input string what, input logic [31:0] actual,
                               input logic [31:0] wanted);
      if (actual !== wanted) begin
         $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, wanted);
         stopOnFailure();
      end
   endtask

   // sequential ISA model, queues every register write in program order
   // and returns how many unknown opcodes it met
   function automatic int runModel(output int steps);
      logic [dataWidth-1:0] regs [regCount];
      logic [dataWidth-1:0] dmem [dmemWords];
      logic [dataWidth-1:0] pc;
      logic [dataWidth-1:0] inst;
      logic [dataWidth-1:0] a;
      logic [dataWidth-1:0] b;
      logic [dataWidth-1:0] ea;
      logic [dataWidth-1:0] res;
      logic [2:0]           wd;
      logic                 wr;
      logic                 done;
      int                   illegal;

      $readmemh("sim/program.hex", progMem);
      for (int i = 0; i < regCount; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < dmemWords; i++) begin
         dmem[i] = '0;
      end
      pc      = '0;
      done    = 1'b0;
      illegal = 0;
      steps   = 0;
      while (!done && steps < stepLimit) begin
         inst = progMem[pc[8:1]];
         a    = regs[inst[10:8]];
         b    = regs[inst[7:5]];   // rt, or the data reg of a store
         ea   = a + {{11{inst[4]}}, inst[4:0]};
         pc   = pc + 16'd2;        // branch offsets count from here
         wr   = 1'b0;
         wd   = inst[7:5];
         res  = '0;
         steps++;
         case (inst[15:11])
            opAdd, opSub, opAnd, opXor: begin
               wr = 1'b1;
               wd = inst[4:2];
               case (inst[15:11])
                  opAdd:   res = a + b;
                  opSub:   res = a - b;
                  opAnd:   res = a & b;
                  default: res = a ^ b;
               endcase
            end
            opAddi: begin
               wr  = 1'b1;
               res = ea;
            end
            opLd: begin
               wr  = 1'b1;
               res = dmem[ea[8:1]];
            end
            opSt:   dmem[ea[8:1]] = b;
            opBeqz: if (a == '0) pc = pc + {{8{inst[7]}}, inst[7:0]};
            opBnez: if (a != '0) pc = pc + {{8{inst[7]}}, inst[7:0]};
            opJ:    pc = pc + {{5{inst[10]}}, inst[10:0]};
            opHalt: done = 1'b1;
            opNop:  wr = 1'b0;
            default: illegal++;   // behaves as a nop
         endcase
         if (wr) begin
            regs[wd] = res;
            expected.push_back(wbEntry'{wd, res});
         end
      end
      return illegal;
   endfunction

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      arstN = 1'b0;
      illegalExpected = runModel(modelSteps);
      repeat (4) @(posedge clk);
      arstN <= 1'b1;
      @(posedge halted);
      repeat (4) @(posedge clk);   // room for a stray writeback
      compareValue("writebacks left in the expected queue", 32'(expected.size()), 32'd0);
      compareValue("count of err pulses", 32'(errSeen), 32'(illegalExpected));
      $display("PASS: all tests");
      $finish;
   end

   // trace compare, mid-cycle where wbTrace and err are settled
   always @(negedge clk) begin
      wbEntry want;
      if (arstN && wbTrace.en) begin
         if (expected.size() == 0) begin
            $display("Unexpected writeback of r%0d at %0t ns, the model has no more writes",
                     wbTrace.dest, $time);
            stopOnFailure();
         end else begin
            want = expected.pop_front();
            compareValue("writeback dest", 32'(wbTrace.dest), 32'(want.dest));
            compareValue("writeback data", 32'(wbTrace.data), 32'(want.data));
         end
      end
      if (arstN && err) errSeen++;
   end

   // 8 cycles per executed word, times 4 for stalls and flushes
   initial begin
      @(posedge arstN);
      repeat (modelSteps * 32) @(posedge clk);
      $display("Timeout: the processor never halted within %0d cycles", modelSteps * 32);
      stopOnFailure();
   end

endmodule

// File: sim/proc_properties.sv
// Pipeline control checks, bound into proc
// stall holds fetch, redirect squashes both younger slots, halted is sticky and final
module procProperties (
   input logic              clk,
   input logic              arstN,
   input logic              stall,
   input logic              redirect,
   input logic              halted,
   input procPkg::fetchReg  fetchBus,
   input procPkg::decodeReg decodeBus,
   input procPkg::writeBack wbTrace
);
   timeunit 1ns;
   timeprecision 1ps;

   stallHoldsFetch: assert property (@(posedge clk) disable iff (!arstN)
      stall && !redirect |=> $stable(fetchBus))
      else $error("fetch register moved while decode was stalled");

   redirectFlushes: assert property (@(posedge clk) disable iff (!arstN)
      redirect |=> !fetchBus.valid && !decodeBus.valid)   // two bubbles behind the branch
      else $error("an instruction behind a taken branch was not squashed");

   haltedSticky: assert property (@(posedge clk) disable iff (!arstN)
      halted |=> halted)
      else $error("halted fell while out of reset");

   noWritebackAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
      halted |-> !wbTrace.en)
      else $error("writeback seen after the processor halted");

endmodule

bind proc procProperties props (
   .clk       (clk),
   .arstN     (arstN),
   .stall     (stall),
   .redirect  (redirect),
   .halted    (halted),
   .fetchBus  (fetchBus),
   .decodeBus (decodeBus),
   .wbTrace   (wbTrace)
);

// File: sim/program.hex
// one 16-bit instruction per line in hex, word 0 first
// the comment after each word gives its assembly form
4025 // addi r1, r0, 5
405D // addi r2, r0, -3
4067 // addi r3, r0, 7
408C // addi r4, r0, 12
C154 // add  r5, r1, r2
CB98 // sub  r6, r3, r4
D47C // and  r7, r4, r3
D964 // xor  r1, r1, r3
C128 // add  r2, r1, r1
CAC8 // sub  r2, r2, r6
427F // addi r3, r2, -1
8464 // st   r3, 4(r4)
8CA4 // ld   r5, 4(r4)
C5B8 // add  r6, r5, r5
6004 // beqz r0, +4      taken
4021 // addi r1, r0, 1   skipped
4041 // addi r2, r0, 1   skipped
6802 // bnez r0, +2      falls through
4123 // addi r1, r1, 3
6902 // bnez r1, +2      taken
D924 // xor  r1, r1, r1  skipped
6102 // beqz r1, +2      falls through
2004 // j    +4
4061 // addi r3, r0, 1   skipped
4081 // addi r4, r0, 1   skipped
F94C // unknown opcode 11111
0800 // nop
3FFF // unknown opcode 00111
4043 // addi r2, r0, 3
425F // addi r2, r2, -1  loop top
C75C // add  r7, r7, r2
6AFA // bnez r2, -6      back to loop top
2002 // j    +2
40FF // addi r7, r0, -1  skipped
80E0 // st   r7, 0(r0)
8820 // ld   r1, 0(r0)
0000 // halt
0800 // nop

// File: tb.f
verilog/procPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/proc.sv
sim/proc_properties.sv
sim/procTb.sv

// File: verilog/decodeStage.sv
// decodeStage
// Decodes the instruction word, reads the register file, stalls on
// register hazards and after HALT, flags unknown opcodes
module decodeStage (
   input  logic              clk,
   input  logic              arstN,
   input  procPkg::fetchReg  fetchIn,
   input  logic              flush,
   input  procPkg::writeBack wbIn,
   input  procPkg::decodeReg exDest,
   input  procPkg::execReg   memDest,
   output logic              stall,
   output logic              err,
   output procPkg::decodeReg decodeOut
);
   import procPkg::*;

   logic [dataWidth-1:0] regs [regCount];
   logic [dataWidth-1:0] readA;
   logic [dataWidth-1:0] readB;
   logic [dataWidth-1:0] imm;
   logic [2:0]           srcA;
   logic [2:0]           srcB;
   logic [2:0]           dest;
   instWord              inst;
   execCtrl              ctrl;
   logic                 useA;
   logic                 useB;
   logic                 illegal;
   logic                 hazard;
   logic                 haltSeen;
   logic                 issue;

   // true when a pending write targets a source this instruction reads
   function automatic logic clash(
      input logic       wr,
      input logic [2:0] wrDest,
      input logic       chkA,
      input logic [2:0] regA,
      input logic       chkB,
      input logic [2:0] regB
   );
      return wr && ((chkA && wrDest == regA) || (chkB && wrDest == regB));
   endfunction

   assign inst = fetchIn.inst;
   assign srcA = inst.rType.rs;
   assign srcB = inst.rType.rt;   // same bits as iType.rd, the ST data reg

   always_comb begin
      ctrl    = '0;
      imm     = '0;
      dest    = inst.iType.rd;
      useA    = 1'b1;
      useB    = 1'b0;
      illegal = 1'b0;
      case (inst.rType.opcode)
         opAdd, opSub, opAnd, opXor: begin
            ctrl.aluSel   = aluOp'(inst.rType.opcode[1:0]);
            ctrl.regWrite = 1'b1;
            useB          = 1'b1;
            dest          = inst.rType.rd;
         end
         opAddi, opLd: begin
            ctrl.useImm   = 1'b1;
            ctrl.isLoad   = (inst.iType.opcode == opLd);
            ctrl.regWrite = 1'b1;
            imm           = {{11{inst.iType.imm[4]}}, inst.iType.imm};
         end
         opSt: begin
            ctrl.useImm  = 1'b1;
            ctrl.isStore = 1'b1;
            useB         = 1'b1;
            imm          = {{11{inst.iType.imm[4]}}, inst.iType.imm};
         end
         opBeqz, opBnez: begin
            ctrl.isBeqz = (inst.bType.opcode == opBeqz);
            ctrl.isBnez = (inst.bType.opcode == opBnez);
            imm         = {{8{inst.bType.offset[7]}}, inst.bType.offset};
         end
         opJ: begin
            // 11-bit offset spans the rs and offset fields
            ctrl.isJump = 1'b1;
            useA        = 1'b0;
            imm         = {{5{inst.bType.rs[2]}}, inst.bType.rs, inst.bType.offset};
         end
         opHalt: begin
            ctrl.isHalt = 1'b1;
            useA        = 1'b0;
         end
         opNop: useA = 1'b0;
         default: begin
            illegal = 1'b1;   // runs as a NOP
            useA    = 1'b0;
         end
      endcase
   end

   // the execReg entry is also the write in flight this cycle
   assign hazard = clash(exDest.valid && exDest.ctrl.regWrite, exDest.dest,
                         useA, srcA, useB, srcB)
                || clash(memDest.valid && memDest.regWrite, memDest.dest,
                         useA, srcA, useB, srcB);

   assign stall = fetchIn.valid && (hazard || haltSeen);   // halt is sticky
   assign issue = fetchIn.valid && !stall && !flush;

   // a dependent read only issues once the write has landed
   assign readA = regs[srcA];
   assign readB = regs[srcB];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wbIn.en) begin
         regs[wbIn.dest] <= wbIn.data;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         decodeOut <= '0;
         haltSeen  <= 1'b0;
         err       <= 1'b0;
      end else begin
         err <= issue && illegal;   // one pulse per issued bad opcode
         if (issue && ctrl.isHalt) begin
            haltSeen <= 1'b1;
         end
         decodeOut.valid     <= issue;   // bubble on stall or flush
         decodeOut.ctrl      <= ctrl;
         decodeOut.pcPlus2   <= fetchIn.pcPlus2;
         decodeOut.operandA  <= readA;
         decodeOut.operandB  <= readB;
         decodeOut.storeData <= readB;
         decodeOut.imm       <= imm;
         decodeOut.dest      <= dest;
      end
   end

endmodule

// File: verilog/executeStage.sv
// executeStage
// ALU on register or immediate operand, branch and jump resolution.
// A taken branch drives redirect and target for one cycle
module executeStage (
   input  logic                          clk,
   input  logic                          arstN,
   input  procPkg::decodeReg             decodeIn,
   output logic                          redirect,
   output logic [procPkg::dataWidth-1:0] target,
   output procPkg::execReg               execOut
);
   import procPkg::*;

   logic [dataWidth-1:0] aluB;
   logic [dataWidth-1:0] aluOut;
   logic                 isZero;
   logic                 taken;

   assign aluB = decodeIn.ctrl.useImm ? decodeIn.imm : decodeIn.operandB;

   always_comb begin
      case (decodeIn.ctrl.aluSel)
         aluAdd:  aluOut = decodeIn.operandA + aluB;
         aluSub:  aluOut = decodeIn.operandA - aluB;
         aluAnd:  aluOut = decodeIn.operandA & aluB;
         default: aluOut = decodeIn.operandA ^ aluB;
      endcase
   end

   // branch condition on rs only
   assign isZero = (decodeIn.operandA == '0);
   assign taken  = decodeIn.ctrl.isJump
                || (decodeIn.ctrl.isBeqz && isZero)
                || (decodeIn.ctrl.isBnez && !isZero);

   assign redirect = decodeIn.valid && taken;
   assign target   = decodeIn.pcPlus2 + decodeIn.imm;   // relative to PC+2

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         execOut <= '0;
      end else begin
         execOut.valid     <= decodeIn.valid;
         // decode leaves regWrite low for branches, jumps and stores
         execOut.regWrite  <= decodeIn.ctrl.regWrite;
         execOut.isLoad    <= decodeIn.ctrl.isLoad;
         execOut.isStore   <= decodeIn.ctrl.isStore;
         execOut.isHalt    <= decodeIn.ctrl.isHalt;
         execOut.aluResult <= aluOut;   // also the ld/st address
         execOut.storeData <= decodeIn.storeData;
         execOut.dest      <= decodeIn.dest;
      end
   end

endmodule

// File: verilog/fetchStage.sv
// fetchStage
// PC register and instruction ROM. Reads the word at PC every cycle and
// registers it with PC+2, holds on stall, jumps to target on redirect
module fetchStage (
   input  logic                           clk,
   input  logic                           arstN,
   input  logic                           stall,
   input  logic                           redirect,
   input  logic [procPkg::dataWidth-1:0]  target,
   output procPkg::fetchReg               fetchOut
);
   import procPkg::*;

   logic [dataWidth-1:0] imem [imemWords];
   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] pcPlus2;
   instWord              word;

   // program image, word addressed
   initial begin
      $readmemh("program.hex", imem);
   end

   assign word    = imem[pc[8:1]];
   assign pcPlus2 = pc + 16'd2;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc       <= '0;
         fetchOut <= '0;
      end else if (redirect) begin
         // taken branch in execute wins over a decode stall
         pc             <= target;
         fetchOut.valid <= 1'b0;   // bubble behind the branch
      end else if (!stall) begin
         pc               <= pcPlus2;
         fetchOut.valid   <= 1'b1;
         fetchOut.pcPlus2 <= pcPlus2;
         fetchOut.inst    <= word;
      end
      // stall with no redirect: pc and fetchOut hold
   end

endmodule

// File: verilog/memStage.sv
// memStage
// Data memory with load and store, writeback data select and the
// sticky halted flag
module memStage (
   input  logic              clk,
   input  logic              arstN,
   input  procPkg::execReg   execIn,
   output procPkg::writeBack wbOut,
   output logic              halted
);
   import procPkg::*;

   logic [dataWidth-1:0] dmem [dmemWords];
   logic [dataWidth-1:0] loadData;
   logic [7:0]           addr;

   assign addr     = execIn.aluResult[8:1];   // word address
   assign loadData = dmem[addr];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < dmemWords; i++) begin
            dmem[i] <= '0;
         end
      end else if (execIn.valid && execIn.isStore) begin
         dmem[addr] <= execIn.storeData;
      end
   end

   // writeback strobe, combinational from the exec register
   always_comb begin
      wbOut.en   = execIn.valid && execIn.regWrite;
      wbOut.dest = execIn.dest;
      wbOut.data = execIn.isLoad ? loadData : execIn.aluResult;
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         halted <= 1'b0;
      end else if (execIn.valid && execIn.isHalt) begin
         halted <= 1'b1;   // held until reset
      end
   end

endmodule

// File: verilog/proc.sv
// proc
// Top level of the four-stage 16-bit pipeline: fetch, decode, execute
// and memory/writeback, with the writeback stream exposed as a trace
module proc (
   input  logic              clk,
   input  logic              arstN,
   output logic              err,
   output logic              halted,
   output procPkg::writeBack wbTrace
);
   import procPkg::*;

   fetchReg              fetchBus;
   decodeReg             decodeBus;
   execReg               execBus;
   logic                 stall;
   logic                 redirect;
   logic [dataWidth-1:0] target;

   fetchStage fetch (
      .clk      (clk),
      .arstN    (arstN),
      .stall    (stall),
      .redirect (redirect),
      .target   (target),
      .fetchOut (fetchBus)
   );

   decodeStage decode (
      .clk       (clk),
      .arstN     (arstN),
      .fetchIn   (fetchBus),
      .flush     (redirect),   // squash the instruction behind a branch
      .wbIn      (wbTrace),
      .exDest    (decodeBus),
      .memDest   (execBus),
      .stall     (stall),
      .err       (err),
      .decodeOut (decodeBus)
   );

   executeStage execute (
      .clk      (clk),
      .arstN    (arstN),
      .decodeIn (decodeBus),
      .redirect (redirect),
      .target   (target),
      .execOut  (execBus)
   );

   // writeback feeds the register file and the trace port
   memStage mem (
      .clk    (clk),
      .arstN  (arstN),
      .execIn (execBus),
      .wbOut  (wbTrace),
      .halted (halted)
   );

endmodule

// File: verilog/procPkg.sv
// procPkg
// ISA constants, the instruction word views and the pipeline register
// layouts shared by the four stages of the 16-bit processor
package procPkg;

   localparam int dataWidth = 16;
   localparam int regCount  = 8;
   localparam int imemWords = 256;
   localparam int dmemWords = 256;

   // 5-bit opcodes, low two bits of the reg-reg group select the ALU op
   localparam logic [4:0] opHalt = 5'b00000;
   localparam logic [4:0] opNop  = 5'b00001;
   localparam logic [4:0] opJ    = 5'b00100;
   localparam logic [4:0] opAddi = 5'b01000;
   localparam logic [4:0] opBeqz = 5'b01100;
   localparam logic [4:0] opBnez = 5'b01101;
   localparam logic [4:0] opSt   = 5'b10000;
   localparam logic [4:0] opLd   = 5'b10001;
   localparam logic [4:0] opAdd  = 5'b11000;
   localparam logic [4:0] opSub  = 5'b11001;
   localparam logic [4:0] opAnd  = 5'b11010;
   localparam logic [4:0] opXor  = 5'b11011;

   typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluXor} aluOp;

   // one word, field layout depends on the opcode
   typedef union packed {
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [2:0] rt;
         logic [2:0] rd;
         logic [1:0] spare;
      } rType;
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [2:0] rd;
         logic [4:0] imm;
      } iType;
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [7:0] offset;
      } bType;
   } instWord;

   typedef struct packed {
      logic                 valid;
      logic [dataWidth-1:0] pcPlus2;
      instWord              inst;
   } fetchReg;

   typedef struct packed {
      aluOp aluSel;
      logic useImm;
      logic isLoad;
      logic isStore;
      logic isBeqz;
      logic isBnez;
      logic isJump;
      logic regWrite;
      logic isHalt;
   } execCtrl;

   typedef struct packed {
      logic                 valid;
      execCtrl              ctrl;
      logic [dataWidth-1:0] pcPlus2;
      logic [dataWidth-1:0] operandA;
      logic [dataWidth-1:0] operandB;
      logic [dataWidth-1:0] storeData;
      logic [dataWidth-1:0] imm;      // already sign-extended
      logic [2:0]           dest;
   } decodeReg;

   typedef struct packed {
      logic                 valid;
      logic                 regWrite;
      logic                 isLoad;
      logic                 isStore;
      logic                 isHalt;
      logic [dataWidth-1:0] aluResult;
      logic [dataWidth-1:0] storeData;
      logic [2:0]           dest;
   } execReg;

   typedef struct packed {
      logic                 en;
      logic [2:0]           dest;
      logic [dataWidth-1:0] data;
   } writeBack;

endpackage
